// ==== bench/memory_checker.sv ====
`default_nettype none

module memory_checker (
    input wire logic clock,
    input wire logic reset,
    input wire mem_stage_pkg::exe_bundle_t exe,
    input wire logic flush,
    input wire logic stall,
    input wire mem_stage_pkg::reg_write_t reg0_write,
    input wire mem_stage_pkg::reg_write_t reg1_write,
    output int errors,
    output int checks,
    output int outstanding
);

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic lane;
        logic [4:0] waddr;
        logic [31:0] wdata;
        logic [31:0] deadline;
    } expect_t;

    logic [7:0] mem_image [0:1023];
    expect_t pending_q[$];
    expect_t pend0;
    expect_t pend1;
    logic pend_live;
    logic pend_has0;
    logic pend_has1;
    logic pend_conflict;
    logic [31:0] cycle;

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem_image[i] = 8'h00;
        end
        errors = 0;
        checks = 0;
        outstanding = 0;
        cycle = 32'd0;
        pend_live = 1'b0;
    end

    function automatic logic is_access(input mem_stage_pkg::lane_op_t lane);
        return lane.op.valid & (lane.op.load | lane.op.store);
    endfunction

    function automatic logic [31:0] model_load(input mem_stage_pkg::lane_op_t lane);
        logic [9:0] a;
        logic [7:0] b;
        logic [15:0] h;
        a = lane.address[9:0];
        b = mem_image[a];
        h = {mem_image[a + 10'd1], mem_image[a]};
        case (lane.size)
            mem_stage_pkg::size_byte: return lane.unsigned_load ? {24'd0, b} : {{24{b[7]}}, b};
            mem_stage_pkg::size_half: return lane.unsigned_load ? {16'd0, h} : {{16{h[15]}}, h};
            default: return {mem_image[a + 10'd3], mem_image[a + 10'd2], h};
        endcase
    endfunction

    // loads read the image before this lane's store, later lanes see the store
    task automatic apply_lane(input mem_stage_pkg::lane_op_t lane, output logic has,
                              output expect_t e);
        logic [9:0] a;
        a = lane.address[9:0];
        has = lane.op.valid & lane.op.wren & (lane.waddr != 5'd0);
        e.lane = 1'b0;
        e.waddr = lane.waddr;
        e.wdata = lane.op.load ? model_load(lane) : lane.wdata;
        e.deadline = 32'd0;
        if (lane.op.valid & lane.op.store) begin
            mem_image[a] = lane.sdata[7:0];
            if (lane.size != mem_stage_pkg::size_byte) begin
                mem_image[a + 10'd1] = lane.sdata[15:8];
            end
            if (lane.size == mem_stage_pkg::size_word) begin
                mem_image[a + 10'd2] = lane.sdata[23:16];
                mem_image[a + 10'd3] = lane.sdata[31:24];
            end
        end
    endtask

    task automatic check_port(input logic lane, input mem_stage_pkg::reg_write_t w);
        int idx;
        idx = -1;
        if (w.wren) begin
            checks++;
            for (int i = 0; i < pending_q.size(); i++) begin
                if (idx < 0 && pending_q[i].lane == lane) begin
                    idx = i;
                end
            end
            if (idx < 0) begin
                errors++;
                $display("** Error at %0t: lane %0d wrote x%0d = %h with no write pending",
                         $time, lane, w.waddr, w.wdata);
            end else begin
                if (w.waddr != pending_q[idx].waddr || w.wdata != pending_q[idx].wdata) begin
                    errors++;
                    $display("** Error at %0t: lane %0d wrote x%0d = %h, expected x%0d = %h",
                             $time, lane, w.waddr, w.wdata, pending_q[idx].waddr,
                             pending_q[idx].wdata);
                end
                pending_q.delete(idx);
            end
        end
    endtask

    // sampled at the falling edge, where every DUT output has settled
    always @(negedge clock) begin
        if (!reset) begin
            pend_live = 1'b0;
        end else begin
            cycle = cycle + 32'd1;
            checks++;
            if (stall !== (pend_live & pend_conflict & ~flush)) begin
                errors++;
                $display("** Error at %0t: stall is %b, expected %b", $time, stall,
                         pend_live & pend_conflict & ~flush);
            end
            if (pend_live && !flush) begin
                pend0.deadline = cycle + 32'd4;
                pend1.deadline = cycle + 32'd4;
                if (pend_has0) begin
                    pending_q.push_back(pend0);
                end
                if (pend_has1) begin
                    pending_q.push_back(pend1);
                end
            end
            pend_live = 1'b0;
            check_port(1'b0, reg0_write);
            check_port(1'b1, reg1_write);
            for (int i = pending_q.size() - 1; i >= 0; i--) begin
                if (cycle > pending_q[i].deadline) begin
                    errors++;
                    $display("expected write to x%0d on lane %0d did not appear within 4 cycles",
                             pending_q[i].waddr, pending_q[i].lane);
                    pending_q.delete(i);
                end
            end
            if (!stall) begin
                apply_lane(exe.lane0, pend_has0, pend0);
                pend_has1 = 1'b0;
                if (!exe.lane0.op.fence) begin
                    apply_lane(exe.lane1, pend_has1, pend1);
                end
                pend1.lane = 1'b1;
                pend_conflict = is_access(exe.lane0) & is_access(exe.lane1)
                              & ~exe.lane0.op.fence
                              & (exe.lane0.address[3:2] == exe.lane1.address[3:2]);
                pend_live = 1'b1;
            end
        end
        outstanding = pending_q.size() + ((pend_live && (pend_has0 || pend_has1)) ? 1 : 0);
    end

endmodule

`default_nettype wire

// ==== bench/memory_subsystem_tb.sv ====
`default_nettype none

module memory_subsystem_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic clock;
    logic reset;
    logic flush;
    logic stall;
    mem_stage_pkg::exe_bundle_t exe;
    mem_stage_pkg::reg_write_t reg0_write;
    mem_stage_pkg::reg_write_t reg1_write;
    int err_count;
    int check_count;
    int outstanding;
    int base_errors;
    int tests_run;
    logic timed_out;
    logic [31:0] lfsr_state;

    memory_subsystem memory_subsystem_i (
        .clock(clock),
        .reset(reset),
        .exe(exe),
        .flush(flush),
        .stall(stall),
        .reg0_write(reg0_write),
        .reg1_write(reg1_write)
    );

    memory_checker memory_checker_i (
        .clock(clock),
        .reset(reset),
        .exe(exe),
        .flush(flush),
        .stall(stall),
        .reg0_write(reg0_write),
        .reg1_write(reg1_write),
        .errors(err_count),
        .checks(check_count),
        .outstanding(outstanding)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] res;
        logic b;
        res = 32'd0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (b ? 32'h80200003 : 32'h0);
            res = {res[30:0], b};
        end
        return res;
    endfunction

    function automatic mem_stage_pkg::lane_op_t alu_lane(input logic [4:0] waddr,
                                                         input logic [31:0] wdata);
        mem_stage_pkg::lane_op_t l;
        l = mem_stage_pkg::init_lane;
        l.op.valid = 1'b1;
        l.op.wren = 1'b1;
        l.waddr = waddr;
        l.wdata = wdata;
        return l;
    endfunction

    function automatic mem_stage_pkg::lane_op_t load_lane(input logic [31:0] addr,
        input mem_stage_pkg::lsu_size_t size, input logic uns, input logic [4:0] waddr);
        mem_stage_pkg::lane_op_t l;
        l = alu_lane(waddr, 32'hdeadbeef);
        l.op.load = 1'b1;
        l.address = addr;
        l.size = size;
        l.unsigned_load = uns;
        return l;
    endfunction

    function automatic mem_stage_pkg::lane_op_t store_lane(input logic [31:0] addr,
        input mem_stage_pkg::lsu_size_t size, input logic [31:0] sdata);
        mem_stage_pkg::lane_op_t l;
        l = mem_stage_pkg::init_lane;
        l.op.valid = 1'b1;
        l.op.store = 1'b1;
        l.address = addr;
        l.size = size;
        l.sdata = sdata;
        return l;
    endfunction

    function automatic mem_stage_pkg::lane_op_t fence_lane();
        mem_stage_pkg::lane_op_t l;
        l = mem_stage_pkg::init_lane;
        l.op.valid = 1'b1;
        l.op.fence = 1'b1;
        return l;
    endfunction

    // addresses stay within the 256 words and are aligned to the size
    function automatic logic [31:0] rand_addr(input mem_stage_pkg::lsu_size_t size);
        logic [31:0] t;
        t = rand_bits(10);
        case (size)
            mem_stage_pkg::size_byte: return {22'd0, t[9:0]};
            mem_stage_pkg::size_half: return {22'd0, t[9:1], 1'b0};
            default: return {22'd0, t[9:2], 2'b00};
        endcase
    endfunction

    function automatic mem_stage_pkg::lsu_size_t rand_size();
        logic [31:0] t;
        t = rand_bits(2);
        return (t[1:0] == 2'd3) ? mem_stage_pkg::size_word : mem_stage_pkg::lsu_size_t'(t[1:0]);
    endfunction

    function automatic mem_stage_pkg::lane_op_t rand_lane();
        logic [31:0] k;
        logic [31:0] w;
        mem_stage_pkg::lsu_size_t s;
        k = rand_bits(3);
        w = rand_bits(5);
        s = rand_size();
        if (k[2:0] < 3'd3) begin
            return alu_lane(w[4:0], rand_bits(32));
        end else if (k[2:0] < 3'd5) begin
            return load_lane(rand_addr(s), s, k[0], w[4:0]);
        end else if (k[2:0] < 3'd7) begin
            return store_lane(rand_addr(s), s, rand_bits(32));
        end
        return fence_lane();
    endfunction

    function automatic logic same_bank(input mem_stage_pkg::exe_bundle_t p);
        return p.lane0.op.valid & (p.lane0.op.load | p.lane0.op.store) & ~p.lane0.op.fence
             & p.lane1.op.valid & (p.lane1.op.load | p.lane1.op.store)
             & (p.lane0.address[3:2] == p.lane1.address[3:2]);
    endfunction

    task automatic report_timeout(input string why);
        $display("%0s", why);
        timed_out = 1'b1;
    endtask

    // drives a pair and returns at the edge that accepts it, fl flushes it a cycle later
    task automatic send_pair(input mem_stage_pkg::lane_op_t l0, input mem_stage_pkg::lane_op_t l1,
                             input logic fl);
        int waited;
        logic accepted;
        if (timed_out) begin
            return;
        end
        waited = 0;
        exe <= '{lane0: l0, lane1: l1};
        do begin
            @(negedge clock);
            accepted = ~stall;
            @(posedge clock);
            flush <= 1'b0;
            waited++;
        end while (!accepted && waited <= 20);
        if (!accepted) begin
            report_timeout("stall did not release within 20 cycles");
        end else begin
            flush <= fl;
        end
    endtask

    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        send_pair(mem_stage_pkg::init_lane, mem_stage_pkg::init_lane, 1'b0);
        while (!timed_out && outstanding != 0 && waited <= 20) begin
            @(posedge clock);
            waited++;
        end
        if (!timed_out && outstanding != 0) begin
            report_timeout("expected register writes never drained");
        end
        if (!timed_out) begin
            tests_run++;
            $display("test %0d %0s: %0d errors", tests_run, name, err_count - base_errors);
            base_errors = err_count;
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] w;
        mem_stage_pkg::lsu_size_t s;
        mem_stage_pkg::lane_op_t l0;
        mem_stage_pkg::lane_op_t l1;
        lfsr_state = 32'h570ffa94;
        reset = 1'b0;
        flush = 1'b0;
        exe = '0;
        base_errors = 0;
        tests_run = 0;
        timed_out = 1'b0;
        repeat (10) @(posedge clock);
        reset <= 1'b1;
        @(posedge clock);

        for (int i = 0; i < 8; i++) begin
            w = rand_bits(10);
            send_pair(alu_lane(w[4:0], rand_bits(32)),
                      alu_lane((i % 3 == 0) ? 5'd0 : w[9:5], rand_bits(32)), 1'b0);
        end
        finish_test("alu pairs");

        for (int i = 0; i < 6; i++) begin
            s = mem_stage_pkg::lsu_size_t'(2'(i % 3));
            a = rand_addr(s);
            w = rand_bits(10);
            send_pair(store_lane(a, s, rand_bits(32)), alu_lane(w[4:0], rand_bits(32)), 1'b0);
            send_pair(load_lane(a, s, 1'b0, w[4:0] | 5'd1), load_lane(a, s, 1'b1, w[9:5] | 5'd1),
                      1'b0);
        end
        finish_test("store then load");

        for (int i = 0; i < 4; i++) begin
            a = rand_addr(mem_stage_pkg::size_word);
            w = rand_bits(10);
            send_pair(store_lane(a, mem_stage_pkg::size_word, rand_bits(32)),
                      load_lane(a, mem_stage_pkg::size_word, 1'b0, w[4:0] | 5'd1), 1'b0);
            send_pair(store_lane(a, mem_stage_pkg::size_byte, rand_bits(32)),
                      load_lane(a ^ 32'h10, mem_stage_pkg::size_word, 1'b0, w[9:5] | 5'd1), 1'b0);
        end
        finish_test("same bank");

        for (int i = 0; i < 3; i++) begin
            a = rand_addr(mem_stage_pkg::size_word);
            send_pair(fence_lane(), store_lane(a, mem_stage_pkg::size_word, rand_bits(32)), 1'b0);
            send_pair(load_lane(a, mem_stage_pkg::size_word, 1'b0, 5'd7), alu_lane(5'd8, 32'd1),
                      1'b0);
        end
        finish_test("fence");

        a = rand_addr(mem_stage_pkg::size_word);
        send_pair(alu_lane(5'd3, rand_bits(32)), alu_lane(5'd4, rand_bits(32)), 1'b1);
        send_pair(store_lane(a, mem_stage_pkg::size_word, rand_bits(32)),
                  alu_lane(5'd5, rand_bits(32)), 1'b1);
        // the flush must also drop the stall of a same-bank pair
        send_pair(store_lane(a, mem_stage_pkg::size_word, rand_bits(32)),
                  load_lane(a, mem_stage_pkg::size_word, 1'b0, 5'd10), 1'b1);
        send_pair(load_lane(a, mem_stage_pkg::size_word, 1'b0, 5'd6), alu_lane(5'd9, 32'd2), 1'b0);
        finish_test("flush");

        for (int i = 0; i < 200; i++) begin
            l0 = rand_lane();
            l1 = rand_lane();
            w = rand_bits(3);
            send_pair(l0, l1, ~same_bank('{lane0: l0, lane1: l1}) & (w[2:0] == 3'd0));
        end
        finish_test("random mix");

        $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== memory_subsystem.f ====
verilog/mem_stage_pkg.sv
verilog/load_format.sv
verilog/memory_stage.sv
verilog/banked_data_memory.sv
verilog/memory_subsystem.sv
bench/memory_checker.sv
bench/memory_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the simulation with Verilator and runs it, the exit status follows the result
verilator --binary --timing --timescale 1ns/1ps --top-module memory_subsystem_tb \
    -f memory_subsystem.f -o memory_subsystem_sim || exit 1
out=$(./obj_dir/memory_subsystem_sim)
echo "$out"
echo "$out" | grep -qx "Verification passed" && exit 0 || exit 1

// ==== verilog/banked_data_memory.sv ====
`default_nettype none

module banked_data_memory (
    input wire logic clock,
    input wire logic reset,
    input wire mem_stage_pkg::mem_req_t req0,
    input wire mem_stage_pkg::mem_req_t req1,
    output mem_stage_pkg::mem_resp_t resp0,
    output mem_stage_pkg::mem_resp_t resp1
);

    localparam int bank_bits = mem_stage_pkg::bank_bits;
    localparam int row_bits = mem_stage_pkg::row_bits;

    logic hold_valid;
    mem_stage_pkg::mem_req_t hold_req;
    mem_stage_pkg::mem_req_t src1;
    logic new_req;
    logic [bank_bits-1:0] bank0;
    logic [bank_bits-1:0] bank1;
    logic conflict;
    logic serve0;
    logic serve1;
    logic ready0_q;
    logic ready1_q;
    logic [bank_bits-1:0] bank0_q;
    logic [bank_bits-1:0] bank1_q;
    logic [mem_stage_pkg::num_banks-1:0][mem_stage_pkg::xlen-1:0] bank_rdata;

    always_comb begin
        new_req = req0.mem_valid | req1.mem_valid;
        // a new pair while a request is held means the held one's pair was flushed,
        // so it is abandoned
        src1 = (hold_valid & ~new_req) ? hold_req : req1;
        bank0 = req0.mem_addr[2 +: bank_bits];
        bank1 = src1.mem_addr[2 +: bank_bits];
        conflict = req0.mem_valid & src1.mem_valid & (bank0 == bank1);
        serve0 = req0.mem_valid;
        serve1 = src1.mem_valid & ~conflict;
    end

    for (genvar b = 0; b < mem_stage_pkg::num_banks; b++) begin : g_bank
        logic [mem_stage_pkg::xlen-1:0] words [mem_stage_pkg::bank_words];
        logic [mem_stage_pkg::xlen-1:0] rdata_q;
        logic sel0;
        logic sel1;
        mem_stage_pkg::mem_req_t acc;
        logic [row_bits-1:0] row;

        initial begin
            for (int i = 0; i < mem_stage_pkg::bank_words; i++) begin
                words[i] = '0;
            end
        end

        always_comb begin
            sel0 = serve0 & (bank0 == bank_bits'(b));
            sel1 = serve1 & (bank1 == bank_bits'(b));
            acc = sel0 ? req0 : src1;
            row = acc.mem_addr[2 + bank_bits +: row_bits];
        end

        // read returns the word as it was before this access writes it
        always_ff @(posedge clock) begin
            if (sel0 | sel1) begin
                rdata_q <= words[row];
                for (int i = 0; i < mem_stage_pkg::strb_width; i++) begin
                    if (acc.mem_wstrb[i]) begin
                        words[row][8*i +: 8] <= acc.mem_wdata[8*i +: 8];
                    end
                end
            end
        end

        assign bank_rdata[b] = rdata_q;
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            hold_valid <= 1'b0;
            ready0_q <= 1'b0;
            ready1_q <= 1'b0;
        end else begin
            hold_valid <= conflict;
            ready0_q <= serve0;
            ready1_q <= serve1;
        end
    end

    always_ff @(posedge clock) begin
        hold_req <= src1;
        bank0_q <= bank0;
        bank1_q <= bank1;
    end

    always_comb begin
        resp0.mem_ready = ready0_q;
        resp0.mem_rdata = bank_rdata[bank0_q];
        resp1.mem_ready = ready1_q;
        resp1.mem_rdata = bank_rdata[bank1_q];
    end

endmodule

`default_nettype wire

// ==== verilog/load_format.sv ====
`default_nettype none

module load_format (
    input wire logic [mem_stage_pkg::xlen-1:0] rdata,
    input wire mem_stage_pkg::lsu_size_t size,
    input wire logic unsigned_load,
    input wire logic [1:0] offset,
    output logic [mem_stage_pkg::xlen-1:0] result
);

    logic [7:0] byte_sel;
    logic [15:0] half_sel;
    logic byte_ext;
    logic half_ext;

    always_comb begin
        byte_sel = rdata[{offset, 3'b000} +: 8];
        // halves are always aligned, so only the upper offset bit matters
        half_sel = offset[1] ? rdata[31:16] : rdata[15:0];
        byte_ext = ~unsigned_load & byte_sel[7];
        half_ext = ~unsigned_load & half_sel[15];

        case (size)
            mem_stage_pkg::size_byte: begin
                result = {{(mem_stage_pkg::xlen-8){byte_ext}}, byte_sel};
            end
            mem_stage_pkg::size_half: begin
                result = {{(mem_stage_pkg::xlen-16){half_ext}}, half_sel};
            end
            default: begin
                result = rdata;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/mem_stage_pkg.sv ====
`default_nettype none

package mem_stage_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_width = 5;
    localparam int mem_words = 256;
    localparam int num_banks = 4;
    localparam int bank_words = mem_words / num_banks;
    localparam int bank_bits = $clog2(num_banks);
    localparam int row_bits = $clog2(bank_words);
    localparam int strb_width = xlen / 8;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } lsu_size_t;

    // one-hot micro-op class, valid marks a real micro-op in the slot
    typedef struct packed {
        logic valid;
        logic wren;
        logic load;
        logic store;
        logic fence;
    } op_flags_t;

    typedef struct packed {
        op_flags_t op;
        lsu_size_t size;
        logic unsigned_load;
        logic [xlen-1:0] address;
        logic [xlen-1:0] sdata;
        logic [reg_addr_width-1:0] waddr;
        logic [xlen-1:0] wdata;
    } lane_op_t;

    typedef struct packed {
        lane_op_t lane0;
        lane_op_t lane1;
    } exe_bundle_t;

    typedef struct packed {
        logic mem_valid;
        logic [xlen-1:0] mem_addr;
        logic [xlen-1:0] mem_wdata;
        logic [strb_width-1:0] mem_wstrb;
    } mem_req_t;

    typedef struct packed {
        logic mem_ready;
        logic [xlen-1:0] mem_rdata;
    } mem_resp_t;

    typedef struct packed {
        logic wren;
        logic [reg_addr_width-1:0] waddr;
        logic [xlen-1:0] wdata;
    } reg_write_t;

    typedef struct packed {
        logic [xlen-1:0] wdata;
        logic [strb_width-1:0] wstrb;
    } store_data_t;

    typedef struct packed {
        lane_op_t lane0;
        lane_op_t lane1;
        logic ready0;
        logic ready1;
        logic stall;
    } memory_reg_t;

    localparam lane_op_t init_lane = '{
        op: '0,
        size: size_byte,
        unsigned_load: 1'b0,
        address: '0,
        sdata: '0,
        waddr: '0,
        wdata: '0
    };

    localparam memory_reg_t init_memory_reg = '{
        lane0: init_lane,
        lane1: init_lane,
        ready0: 1'b0,
        ready1: 1'b0,
        stall: 1'b0
    };

    // the store value is copied into every byte lane it could land in,
    // so the strobes alone pick the bytes that change
    function automatic store_data_t store_align(
        input logic [xlen-1:0] sdata,
        input lsu_size_t size,
        input logic [1:0] offset
    );
        store_data_t res;
        case (size)
            size_byte: begin
                res.wdata = {4{sdata[7:0]}};
                res.wstrb = 4'b0001 << offset;
            end
            size_half: begin
                res.wdata = {2{sdata[15:0]}};
                res.wstrb = offset[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                res.wdata = sdata;
                res.wstrb = 4'b1111;
            end
        endcase
        return res;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/memory_stage.sv ====
`default_nettype none

module memory_stage (
    input wire logic clock,
    input wire logic reset,
    input wire mem_stage_pkg::exe_bundle_t exe,
    input wire logic flush,
    output mem_stage_pkg::mem_req_t req0,
    output mem_stage_pkg::mem_req_t req1,
    input wire mem_stage_pkg::mem_resp_t resp0,
    input wire mem_stage_pkg::mem_resp_t resp1,
    output mem_stage_pkg::lsu_size_t fmt0_size,
    output logic fmt0_unsigned,
    output logic [1:0] fmt0_offset,
    input wire logic [mem_stage_pkg::xlen-1:0] fmt0_result,
    output mem_stage_pkg::lsu_size_t fmt1_size,
    output logic fmt1_unsigned,
    output logic [1:0] fmt1_offset,
    input wire logic [mem_stage_pkg::xlen-1:0] fmt1_result,
    output logic stall,
    output mem_stage_pkg::reg_write_t reg0_write,
    output mem_stage_pkg::reg_write_t reg1_write
);

    mem_stage_pkg::memory_reg_t r;
    mem_stage_pkg::memory_reg_t rin;
    mem_stage_pkg::memory_reg_t v;

    logic fire0;
    logic fire1;
    logic [mem_stage_pkg::xlen-1:0] data0;
    logic [mem_stage_pkg::xlen-1:0] data1;

    function automatic logic is_access(input mem_stage_pkg::lane_op_t lane);
        return lane.op.valid & (lane.op.load | lane.op.store);
    endfunction

    function automatic mem_stage_pkg::mem_req_t build_req(
        input mem_stage_pkg::lane_op_t lane,
        input logic enable
    );
        mem_stage_pkg::mem_req_t req;
        mem_stage_pkg::store_data_t st;
        st = mem_stage_pkg::store_align(lane.sdata, lane.size, lane.address[1:0]);
        req.mem_valid = enable & is_access(lane);
        req.mem_addr = lane.address;
        req.mem_wdata = st.wdata;
        req.mem_wstrb = lane.op.store ? st.wstrb : '0;
        return req;
    endfunction

    function automatic mem_stage_pkg::reg_write_t make_write(
        input mem_stage_pkg::lane_op_t lane,
        input logic fire,
        input logic [mem_stage_pkg::xlen-1:0] data
    );
        mem_stage_pkg::reg_write_t w;
        w.wren = fire & lane.op.valid & lane.op.wren & (lane.waddr != '0);
        w.waddr = lane.waddr;
        w.wdata = data;
        return w;
    endfunction

    always_comb begin
        v = r;

        v.ready0 = r.ready0 | resp0.mem_ready;
        v.ready1 = r.ready1 | resp1.mem_ready;
        v.stall = (is_access(r.lane0) & ~v.ready0) | (is_access(r.lane1) & ~v.ready1);

        // an access lane writes with its reply, any other lane in the pair's first cycle
        fire0 = ~flush & (is_access(r.lane0) ? resp0.mem_ready : ~r.stall);
        fire1 = ~flush & (is_access(r.lane1) ? resp1.mem_ready : ~r.stall);

        data0 = r.lane0.op.load ? fmt0_result : r.lane0.wdata;
        data1 = r.lane1.op.load ? fmt1_result : r.lane1.wdata;

        if (flush) begin
            v.stall = 1'b0;
        end

        // accept the next pair, a fence in lane 0 kills lane 1 here
        if (!v.stall) begin
            v.lane0 = exe.lane0;
            v.lane1 = exe.lane0.op.fence ? mem_stage_pkg::init_lane : exe.lane1;
            v.ready0 = 1'b0;
            v.ready1 = 1'b0;
        end

        req0 = build_req(exe.lane0, ~v.stall);
        req1 = build_req(exe.lane1, ~v.stall & ~exe.lane0.op.fence);

        fmt0_size = r.lane0.size;
        fmt0_unsigned = r.lane0.unsigned_load;
        fmt0_offset = r.lane0.address[1:0];
        fmt1_size = r.lane1.size;
        fmt1_unsigned = r.lane1.unsigned_load;
        fmt1_offset = r.lane1.address[1:0];

        reg0_write = make_write(r.lane0, fire0, data0);
        reg1_write = make_write(r.lane1, fire1, data1);

        stall = v.stall;
        rin = v;
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            r <= mem_stage_pkg::init_memory_reg;
        end else begin
            r <= rin;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/memory_subsystem.sv ====
`default_nettype none

module memory_subsystem (
    input wire logic clock,
    input wire logic reset,
    input wire mem_stage_pkg::exe_bundle_t exe,
    input wire logic flush,
    output logic stall,
    output mem_stage_pkg::reg_write_t reg0_write,
    output mem_stage_pkg::reg_write_t reg1_write
);

    mem_stage_pkg::mem_req_t req0;
    mem_stage_pkg::mem_req_t req1;
    mem_stage_pkg::mem_resp_t resp0;
    mem_stage_pkg::mem_resp_t resp1;

    mem_stage_pkg::lsu_size_t fmt0_size;
    mem_stage_pkg::lsu_size_t fmt1_size;
    logic fmt0_unsigned;
    logic fmt1_unsigned;
    logic [1:0] fmt0_offset;
    logic [1:0] fmt1_offset;
    logic [mem_stage_pkg::xlen-1:0] fmt0_result;
    logic [mem_stage_pkg::xlen-1:0] fmt1_result;

    memory_stage memory_stage_i (
        .clock(clock),
        .reset(reset),
        .exe(exe),
        .flush(flush),
        .req0(req0),
        .req1(req1),
        .resp0(resp0),
        .resp1(resp1),
        .fmt0_size(fmt0_size),
        .fmt0_unsigned(fmt0_unsigned),
        .fmt0_offset(fmt0_offset),
        .fmt0_result(fmt0_result),
        .fmt1_size(fmt1_size),
        .fmt1_unsigned(fmt1_unsigned),
        .fmt1_offset(fmt1_offset),
        .fmt1_result(fmt1_result),
        .stall(stall),
        .reg0_write(reg0_write),
        .reg1_write(reg1_write)
    );

    banked_data_memory banked_data_memory_i (
        .clock(clock),
        .reset(reset),
        .req0(req0),
        .req1(req1),
        .resp0(resp0),
        .resp1(resp1)
    );

    load_format load_format0_i (
        .rdata(resp0.mem_rdata),
        .size(fmt0_size),
        .unsigned_load(fmt0_unsigned),
        .offset(fmt0_offset),
        .result(fmt0_result)
    );

    load_format load_format1_i (
        .rdata(resp1.mem_rdata),
        .size(fmt1_size),
        .unsigned_load(fmt1_unsigned),
        .offset(fmt1_offset),
        .result(fmt1_result)
    );

endmodule

`default_nettype wire
